// File: all.f
hdl/huff_pkg.sv
hdl/token_fifo.sv
hdl/huff_table_regs.sv
hdl/huff_coder.sv
hdl/bit_packer.sv
hdl/huff_encoder_top.sv
test/huff_tb.sv

// File: run.sh
#!/bin/sh
# builds the huff_tb simulation with Verilator, runs it and scans the log for failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module huff_tb -o huff_sim

status=0
./obj_dir/huff_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
    echo "simulation run reported failure"
    exit 1
fi
exit 0

// File: test/huff_tb.sv
// testbench for huff_encoder_top that checks random tokens against a bitstream model
`timescale 1ns/1ps

module huff_tb;

    localparam int n_stream       = 300;  // continuous ds
    localparam int n_gaps         = 200;  // ds with random gaps
    localparam int n_zero         = 100;  // zero amplitude code-only tokens
    localparam int n_max          = 100;  // size 11 with 16-bit codes
    localparam int n_drop         = 100;  // per half of the en drop test
    localparam int total_tokens   = n_stream + n_gaps + n_zero + n_max + 2 * n_drop;
    localparam int timeout_cycles = total_tokens * 8 + 2000;
    localparam int drain_limit    = 1000;  // xclk cycles for words to come out

    logic                  xclk;
    logic                  xclk2x;
    logic                  rst_n;
    logic                  en;
    logic                  ds;
    huff_pkg::huff_token_t di;
    logic                  tbl_we;
    logic [7:0]            tbl_waddr;
    huff_pkg::huff_entry_t tbl_wdata;
    logic                  word_valid;
    logic [15:0]           word;

    logic [31:0] lfsr = 32'haefa;  // stimulus state
    logic [4:0]  tbl_len [0:255];   // model copy of the code table
    logic [15:0] tbl_code [0:255];
    bit          exp_bits [$];      // expected bitstream with oldest bit first
    logic [15:0] exp_word;
    int          errors          = 0;
    int          words_seen      = 0;
    int          tests_done      = 0;
    int          cycles          = 0;
    int          idle_words      = 0;  // word_valid seen while watched
    int          throttle_cycles = 0;  // ready low while watched
    bit          watch_idle      = 1'b0;
    bit          watch_ready     = 1'b0;
    int          err_mark;
    int          word_mark;

    huff_encoder_top UUT (
        .xclk(xclk), .xclk2x(xclk2x), .rst_n(rst_n), .en(en),
        .ds(ds), .di(di),
        .tbl_we(tbl_we), .tbl_waddr(tbl_waddr), .tbl_wdata(tbl_wdata),
        .word_valid(word_valid), .word(word)
    );

    initial begin
        xclk = 1'b0;
        forever #4 xclk = ~xclk;  // 8 ns
    end

    initial begin
        xclk2x = 1'b0;
        #2;  // first rise lands on the first xclk rise
        forever #2 xclk2x = ~xclk2x;  // 4 ns period rising with xclk
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};  // one step per bit
        end
        return val;
    endfunction

    // signed amplitude whose magnitude has exactly size bits
    function automatic logic [11:0] rand_amp(input int size);
        logic [11:0] mag;
        logic        neg;
        if (size == 0) begin
            return 12'h000;
        end
        mag = 12'(1 << (size - 1)) | 12'(rand_bits(size - 1));
        neg = (rand_bits(1) != 32'd0);
        return neg ? (12'h000 - mag) : mag;
    endfunction

    function automatic huff_pkg::huff_token_t make_token(input int size);
        huff_pkg::huff_token_t t;
        t.run = 4'(rand_bits(4));
        t.amp = rand_amp(size);
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // code bits followed by amplitude bits with negatives sent as amp - 1
    task automatic push_expected(input huff_pkg::huff_token_t t);
        logic [11:0] mag;
        logic [11:0] val;
        logic [7:0]  sym;
        int          size;
        int          len;
        mag  = t.amp[11] ? (12'h000 - t.amp) : t.amp;
        size = 0;
        while (mag != 12'h000) begin
            size++;
            mag = mag >> 1;
        end
        sym = {t.run, 4'(size)};
        len = int'(tbl_len[sym]);
        for (int i = len - 1; i >= 0; i--) begin
            exp_bits.push_back(tbl_code[sym][i]);
        end
        val = t.amp[11] ? (t.amp - 12'd1) : t.amp;
        for (int i = size - 1; i >= 0; i--) begin
            exp_bits.push_back(val[i]);
        end
    endtask

    task automatic send_token(input huff_pkg::huff_token_t t);
        @(posedge xclk);
        ds <= 1'b1;
        di <= t;
        push_expected(t);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge xclk);
            ds <= 1'b0;
        end
    endtask

    task automatic send_random(input int count, input bit gaps);
        for (int i = 0; i < count; i++) begin
            if (gaps) begin
                idle_cycles(int'(rand_bits(2)));  // 0..3 empty xclk cycles
            end
            send_token(make_token(int'(rand_bits(4)) % 12));
        end
        idle_cycles(1);
    endtask

    // full words left in the model mean the DUT lost some
    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_bits.size() >= 16) && (n < drain_limit)) begin
            @(posedge xclk);
            n++;
        end
        if (exp_bits.size() >= 16) begin
            errors++;
            $display("missing words: %0d bits still expected after %0d cycles",
                     exp_bits.size(), n);
        end
    endtask

    task automatic report_test(input int num, input string name);
        tests_done++;
        $display("test %0d %s: %0d words, %0d errors", num, name,
                 words_seen - word_mark, errors - err_mark);
        err_mark  = errors;
        word_mark = words_seen;
    endtask

    // mid-cycle sample of outputs that change on the rising edge
    always @(negedge xclk2x) begin
        if (rst_n && en && word_valid) begin
            if (exp_bits.size() < 16) begin
                errors++;
                $display("unexpected word %h with no full word left in the model", word);
            end else begin
                exp_word = '0;
                repeat (16) exp_word = {exp_word[14:0], exp_bits.pop_front()};
                check_value("word", {16'h0000, word}, {16'h0000, exp_word});
                words_seen++;
            end
        end
        if (watch_idle && word_valid) begin
            idle_words++;
        end
        if (watch_ready && !UUT.ready) begin
            throttle_cycles++;
        end
    end

    always @(posedge xclk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run still going after %0d xclk cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        en        = 1'b0;
        ds        = 1'b0;
        di        = '0;
        tbl_we    = 1'b0;
        tbl_waddr = '0;
        tbl_wdata = '0;
        err_mark  = 0;
        word_mark = 0;
        repeat (10) @(posedge xclk);
        rst_n <= 1'b1;
        repeat (2) @(posedge xclk);

        // test 1 loads the table with en low
        watch_idle = 1'b1;
        for (int i = 0; i < 256; i++) begin
            tbl_len[i]  = (i[3:0] == 4'd11) ? 5'd16 : 5'(1 + rand_bits(4));  // size 11 gets 27 bits
            tbl_code[i] = 16'(rand_bits(16)) & 16'((32'd1 << tbl_len[i]) - 32'd1);
            @(posedge xclk);
            tbl_we    <= 1'b1;
            tbl_waddr <= 8'(i);
            tbl_wdata <= '{len: tbl_len[i], code: tbl_code[i]};
        end
        @(posedge xclk);
        tbl_we <= 1'b0;
        repeat (4) @(posedge xclk);
        watch_idle = 1'b0;
        check_value("word_valid during load", idle_words, 0);
        report_test(1, "table load");

        @(posedge xclk);
        en <= 1'b1;
        repeat (4) @(posedge xclk);

        // test 2 sends back-to-back tokens
        send_random(n_stream, 1'b0);
        wait_drain();
        report_test(2, "continuous stream");

        // test 3 leaves random gaps in ds
        send_random(n_gaps, 1'b1);
        wait_drain();
        report_test(3, "gapped stream");

        // test 4 sends code-only tokens and then 27-bit fields that hold off the coder
        throttle_cycles = 0;
        watch_ready     = 1'b1;
        for (int i = 0; i < n_zero; i++) begin
            send_token(make_token(0));
        end
        for (int i = 0; i < n_max; i++) begin
            send_token(make_token(11));
        end
        idle_cycles(1);
        wait_drain();
        watch_ready = 1'b0;
        check_value("ready throttle seen", {31'd0, throttle_cycles != 0}, 32'd1);
        report_test(4, "zero and max fields");

        // test 5 drops en mid-stream and starts a fresh stream
        send_random(n_drop, 1'b0);
        @(posedge xclk);
        en <= 1'b0;  // FIFO still holds tokens here
        repeat (2) @(posedge xclk);
        idle_words = 0;
        watch_idle = 1'b1;
        repeat (20) @(posedge xclk);
        watch_idle = 1'b0;
        check_value("word_valid after en low", idle_words, 0);
        exp_bits.delete();  // leftover bits dropped in the DUT too
        @(posedge xclk);
        en <= 1'b1;
        repeat (4) @(posedge xclk);
        send_random(n_drop, 1'b0);
        wait_drain();
        report_test(5, "en drop and restart");

        repeat (10) @(posedge xclk);
        $display("%0d tests, %0d words checked, %0d errors", tests_done, words_seen, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: hdl/huff_encoder_top.sv
// JPEG entropy back end top, token FIFO into Huffman coder into 16-bit word packer
`timescale 1ns/1ps

module huff_encoder_top (
    input  logic                  xclk,        // pixel clock
    input  logic                  xclk2x,      // double rate, in phase
    input  logic                  rst_n,
    input  logic                  en,          // stream enable
    input  logic                  ds,          // token strobe
    input  huff_pkg::huff_token_t di,          // run/amplitude token
    input  logic                  tbl_we,      // table load, en low only
    input  logic [7:0]            tbl_waddr,
    input  huff_pkg::huff_entry_t tbl_wdata,
    output logic                  word_valid,  // word strobe, no stall
    output logic [15:0]           word
);

    logic                  en2x;         // single en sync, shared
    logic                  dav;
    huff_pkg::huff_token_t q;
    logic                  want_read;
    logic [7:0]            tbl_raddr;
    huff_pkg::huff_entry_t tbl_rdata;
    logic                  ready;
    logic                  field_valid;
    huff_pkg::huff_field_t field;

    token_fifo u_fifo (
        .xclk(xclk), .xclk2x(xclk2x), .rst_n(rst_n), .en(en),
        .ds(ds), .di(di), .want_read(want_read),
        .dav(dav), .q(q), .en2x(en2x)
    );

    huff_table_regs u_table (
        .xclk(xclk), .xclk2x(xclk2x), .rst_n(rst_n), .en(en),
        .tbl_we(tbl_we), .tbl_waddr(tbl_waddr), .tbl_wdata(tbl_wdata),
        .tbl_raddr(tbl_raddr), .tbl_rdata(tbl_rdata)
    );

    huff_coder u_coder (
        .xclk2x(xclk2x), .rst_n(rst_n), .en2x(en2x),
        .dav(dav), .q(q), .want_read(want_read), .ready(ready),
        .tbl_raddr(tbl_raddr), .tbl_rdata(tbl_rdata),
        .field_valid(field_valid), .field(field)
    );

    bit_packer u_packer (
        .xclk2x(xclk2x), .rst_n(rst_n), .en2x(en2x),
        .field_valid(field_valid), .field(field), .ready(ready),
        .word_valid(word_valid), .word(word)
    );

endmodule

// File: hdl/bit_packer.sv
// bit packer, collects variable-length fields MSB first and emits 16-bit words
`timescale 1ns/1ps

module bit_packer (
    input  logic                  xclk2x,
    input  logic                  rst_n,
    input  logic                  en2x,         // sync clear, drops leftover bits
    input  logic                  field_valid,  // field strobe from coder
    input  huff_pkg::huff_field_t field,
    output logic                  ready,        // fill at most 16
    output logic                  word_valid,   // word strobe
    output logic [15:0]           word          // oldest 16 bits
);

    logic [47:0] bit_buf;  // left aligned, oldest bit at 47
    logic [5:0]  fill;     // valid bits in bit_buf
    logic        emit;     // word leaves this cycle
    logic [5:0]  base;     // fill after the word leaves
    logic [47:0] shifted;  // bit_buf after the word leaves
    logic [47:0] ext;      // incoming field placed behind base
    logic [5:0]  add;      // bits added this cycle

    assign emit       = fill >= 6'd16;
    assign word_valid = emit;
    assign word       = bit_buf[47:32];
    assign ready      = fill <= 6'd16;  // with a 27-bit field still fits in 48

    assign base    = emit ? (fill - 6'd16) : fill;
    assign shifted = emit ? {bit_buf[31:0], 16'h0000} : bit_buf;
    assign add     = field_valid ? {1'b0, field.nbits} : 6'd0;

    // left align the field, then slide it behind what stays
    always_comb begin
        ext = '0;
        if (field_valid) begin
            ext = {{(48 - huff_pkg::field_w){1'b0}}, field.bits} << (6'd48 - {1'b0, field.nbits});
            ext = ext >> base;
        end
    end

    // bits below fill are kept zero, so the OR merge is clean
    always_ff @(posedge xclk2x or negedge rst_n) begin
        if (!rst_n) begin
            bit_buf <= '0;
            fill    <= '0;
        end else if (!en2x) begin
            bit_buf <= '0;  // partial word dropped
            fill    <= '0;
        end else begin
            bit_buf <= shifted | ext;
            fill    <= base + add;
        end
    end

    // holds only while the coder respects ready
    a_fill_bound: assert property (@(posedge xclk2x) disable iff (!rst_n)
        fill <= 6'd48)
        else $error("bit_packer: fill %0d exceeds buffer", fill);

endmodule

// File: hdl/huff_coder.sv
// Huffman coder, turns each FIFO token into a code-plus-amplitude field for the bit packer
`timescale 1ns/1ps

module huff_coder (
    input  logic                  xclk2x,
    input  logic                  rst_n,
    input  logic                  en2x,         // sync clear from the FIFO side
    input  logic                  dav,          // FIFO head valid
    input  huff_pkg::huff_token_t q,            // FIFO head token
    output logic                  want_read,    // one-cycle take pulse
    input  logic                  ready,        // packer has room
    output logic [7:0]            tbl_raddr,    // {run, size}
    input  huff_pkg::huff_entry_t tbl_rdata,    // looked-up entry
    output logic                  field_valid,  // field strobe
    output huff_pkg::huff_field_t field
);

    huff_pkg::coder_state_t      state;
    logic [3:0]                  run_r;       // run of token in flight
    logic [3:0]                  size_r;      // its size category
    logic [huff_pkg::amp_w-1:0]  amp_bits_r;  // its amplitude bits
    logic                        take;        // accept head token this cycle
    logic [3:0]                  size_in;
    logic [huff_pkg::amp_w-1:0]  amp_bits_in;

    // bit length of |amp|, 0 for a zero amplitude
    function automatic logic [3:0] size_of(input logic [11:0] amp);
        logic [11:0] mag;
        logic [3:0]  sz;
        mag = amp[11] ? (~amp + 12'd1) : amp;
        sz  = 4'd0;
        for (int i = 0; i < huff_pkg::amp_w; i++) begin
            if (mag[i]) begin
                sz = 4'(i + 1);  // highest set bit wins
            end
        end
        return sz;
    endfunction

    // low size bits, negative values sent as amp - 1
    function automatic logic [huff_pkg::amp_w-1:0] amp_bits_of(input logic [11:0] amp,
                                                               input logic [3:0]  size);
        logic [11:0] adj;
        logic [11:0] mask;
        adj  = amp[11] ? (amp - 12'd1) : amp;
        mask = (12'd1 << size) - 12'd1;
        return adj[huff_pkg::amp_w-1:0] & mask[huff_pkg::amp_w-1:0];
    endfunction

    assign size_in     = size_of(q.amp);
    assign amp_bits_in = amp_bits_of(q.amp, size_in);
    assign take        = dav && ready &&
                         ((state == huff_pkg::idle) || (state == huff_pkg::emit));
    assign tbl_raddr   = {run_r, size_r};  // held through lookup

    // control
    always_ff @(posedge xclk2x or negedge rst_n) begin
        if (!rst_n) begin
            state       <= huff_pkg::idle;
            want_read   <= 1'b0;
            field_valid <= 1'b0;
        end else if (!en2x) begin
            state       <= huff_pkg::idle;
            want_read   <= 1'b0;
            field_valid <= 1'b0;
        end else begin
            want_read   <= take;                    // FIFO samples it on the negedge
            field_valid <= (state == huff_pkg::emit);
            case (state)
                huff_pkg::idle:   state <= take ? huff_pkg::lookup : huff_pkg::idle;
                huff_pkg::lookup: state <= huff_pkg::emit;
                huff_pkg::emit:   state <= take ? huff_pkg::lookup : huff_pkg::idle;  // 2-cycle rate
                default:          state <= huff_pkg::idle;
            endcase
        end
    end

    // token and field payload
    always_ff @(posedge xclk2x) begin
        if (take) begin
            run_r      <= q.run;
            size_r     <= size_in;
            amp_bits_r <= amp_bits_in;
        end
        if (state == huff_pkg::emit) begin
            field.nbits <= tbl_rdata.len + {1'b0, size_r};
            field.bits  <= ({{(huff_pkg::field_w - huff_pkg::code_w){1'b0}}, tbl_rdata.code}
                            << size_r)
                         | {{(huff_pkg::field_w - huff_pkg::amp_w){1'b0}}, amp_bits_r};
        end
    end

    // every symbol the stream uses must have been loaded
    a_len_loaded: assert property (@(posedge xclk2x) disable iff (!rst_n)
        (en2x && (state == huff_pkg::emit)) |-> (tbl_rdata.len != 5'd0))
        else $error("huff_coder: zero code length for symbol %02h", tbl_raddr);

endmodule

// File: hdl/huff_table_regs.sv
// 256-entry Huffman code table, loaded at xclk while en is low and read by the coder at xclk2x
`timescale 1ns/1ps

module huff_table_regs (
    input  logic                  xclk,       // write clock, outside loader
    input  logic                  xclk2x,     // read clock, coder side
    input  logic                  rst_n,
    input  logic                  en,         // encoder running
    input  logic                  tbl_we,     // write strobe
    input  logic [7:0]            tbl_waddr,  // {run, size}
    input  huff_pkg::huff_entry_t tbl_wdata,  // len + code
    input  logic [7:0]            tbl_raddr,  // symbol index from coder
    output huff_pkg::huff_entry_t tbl_rdata   // entry, one xclk2x later
);

    huff_pkg::huff_entry_t mem [0:255];  // one entry per symbol

    // load port
    always_ff @(posedge xclk) begin
        if (tbl_we) begin
            mem[tbl_waddr] <= tbl_wdata;
        end
    end

    // synchronous read, registered output
    always_ff @(posedge xclk2x) begin
        tbl_rdata <= mem[tbl_raddr];
    end

    // table is static while the coder runs, so no write/read collision
    a_load_while_idle: assert property (@(posedge xclk) disable iff (!rst_n)
        tbl_we |-> !en)
        else $error("huff_table_regs: table write while en high");

    // the packer count arithmetic relies on real code lengths
    a_len_range: assert property (@(posedge xclk) disable iff (!rst_n)
        tbl_we |-> (tbl_wdata.len >= 5'd1) && (tbl_wdata.len <= 5'(huff_pkg::code_w)))
        else $error("huff_table_regs: len %0d out of 1..16", tbl_wdata.len);

endmodule

// File: hdl/token_fifo.sv
// dual-clock token FIFO, written at xclk and drained on the xclk2x negedge by the coder
`timescale 1ns/1ps

module token_fifo (
    input  logic                  xclk,       // pixel clock on the write side
    input  logic                  xclk2x,     // double rate read clock, falling edge used
    input  logic                  rst_n,
    input  logic                  en,         // sync clear in the xclk domain
    input  logic                  ds,         // token strobe
    input  huff_pkg::huff_token_t di,         // token in
    input  logic                  want_read,  // coder pulse while dav is high
    output logic                  dav,        // output register holds a token
    output huff_pkg::huff_token_t q,          // head token
    output logic                  en2x        // en resampled for the xclk2x side
);

    logic [huff_pkg::tok_w-1:0]   mem [0:(1 << huff_pkg::fifo_aw) - 1];  // inferred dual-port RAM
    logic [huff_pkg::fifo_aw-1:0] wa;       // write pointer
    logic [huff_pkg::fifo_aw-1:0] ra;       // read pointer
    logic                         synci;    // flips once per written token
    logic [1:0]                   synco;    // synci in the xclk2x domain
    logic                         sync_we;  // one xclk2x pulse per token
    logic [huff_pkg::fifo_aw:0]   ram_cnt;  // words in RAM not yet announced
    logic                         ram_dav;  // RAM holds something to load
    logic                         load_q;   // move RAM head into q

    // write side without overrun detection
    always_ff @(posedge xclk or negedge rst_n) begin
        if (!rst_n) begin
            wa    <= '0;
            synci <= 1'b0;
        end else if (!en) begin
            wa    <= '0;
            synci <= 1'b0;
        end else if (ds) begin
            wa    <= wa + 1'b1;
            synci <= ~synci;  // RAM write lands at this same edge
        end
    end

    always_ff @(posedge xclk) begin
        if (ds && en) begin
            mem[wa] <= di;
        end
    end

    // crossing into xclk2x on its falling edge
    always_ff @(negedge xclk2x or negedge rst_n) begin
        if (!rst_n) begin
            en2x    <= 1'b0;
            synco   <= 2'b00;
            sync_we <= 1'b0;
        end else begin
            en2x    <= en;
            synco   <= {synco[0], synci};
            sync_we <= en2x && (synco[0] != synco[1]);  // any edge of synci
        end
    end

    assign ram_dav = sync_we || (ram_cnt != '0);
    assign load_q  = ram_dav && (!dav || want_read);  // refill when empty or consumed

    // read pointer, pending count and output flag
    always_ff @(negedge xclk2x or negedge rst_n) begin
        if (!rst_n) begin
            ra      <= '0;
            ram_cnt <= '0;
            dav     <= 1'b0;
        end else if (!en2x) begin
            ra      <= '0;
            ram_cnt <= '0;
            dav     <= 1'b0;
        end else begin
            if (load_q) begin
                ra <= ra + 1'b1;
            end
            if (sync_we && !load_q) begin
                ram_cnt <= ram_cnt + 1'b1;
            end else if (!sync_we && load_q) begin
                ram_cnt <= ram_cnt - 1'b1;  // sync_we word goes straight out otherwise
            end
            if (load_q) begin
                dav <= 1'b1;
            end else if (want_read) begin
                dav <= 1'b0;  // last token taken with nothing behind it
            end
        end
    end

    // head token register, loaded together with dav
    always_ff @(negedge xclk2x) begin
        if (load_q && en2x) begin
            q <= huff_pkg::huff_token_t'(mem[ra]);
        end
    end

    // the coder must only pulse want_read against a held token
    a_read_with_dav: assert property (@(negedge xclk2x) disable iff (!rst_n)
        want_read |-> dav)
        else $error("token_fifo: want_read while dav low");

endmodule

// File: hdl/huff_pkg.sv
// shared widths, token/table/field structs and coder states for the JPEG entropy back end
package huff_pkg;

    // widths fixed by the JPEG baseline format
    localparam int tok_w   = 16;  // token word, run + amplitude
    localparam int fifo_aw = 10;  // 1024 token FIFO
    localparam int code_w  = 16;  // longest Huffman code
    localparam int amp_w   = 11;  // amplitude bits for size 0..11
    localparam int field_w = 27;  // code_w + amp_w

    // run/amplitude token as it arrives from the quantizer side
    typedef struct packed {
        logic [3:0]  run;  // zero run length
        logic [11:0] amp;  // signed coefficient
    } huff_token_t;

    // one code table entry, indexed by {run, size}
    typedef struct packed {
        logic [4:0]        len;   // code length 1..16
        logic [code_w-1:0] code;  // right aligned
    } huff_entry_t;

    // variable-length field handed from coder to packer
    typedef struct packed {
        logic [4:0]         nbits;  // valid bit count 1..27
        logic [field_w-1:0] bits;   // first-sent bit at nbits-1
    } huff_field_t;

    // coder FSM
    typedef enum logic [1:0] {
        idle   = 2'd0,  // waiting for dav and ready
        lookup = 2'd1,  // symbol index on table address
        emit   = 2'd2   // table entry back, field built
    } coder_state_t;

endpackage
